// File: common/armPkg.sv
`default_nettype none

package armPkg;

    // Memory sizes in 32-bit words
    localparam int IMEM_WORDS  = 128;
    localparam int DMEM_WORDS  = 64;
    localparam int IMEM_ADDR_W = $clog2(IMEM_WORDS);
    localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);
    localparam int GPR_COUNT   = 15;  // R0-R14, R15 lives in the pc register

    localparam logic [31:0] PC_READ_OFFSET = 32'd8;  // R15 reads as pc + 8
    localparam string PROGRAM_FILE = "test/program.hex";

    typedef logic [31:0] word_t;
    typedef logic [3:0]  regIdx_t;

    localparam regIdx_t PC_REG = 4'd15;

    typedef enum logic [3:0] {
        COND_EQ = 4'b0000,
        COND_NE = 4'b0001,
        COND_AL = 4'b1110
    } condCode_e;

    // Data-processing opcode field, only the supported subset is named
    typedef enum logic [3:0] {
        OP_AND = 4'b0000,
        OP_SUB = 4'b0010,
        OP_ADD = 4'b0100,
        OP_CMP = 4'b1010,
        OP_ORR = 4'b1100,
        OP_MOV = 4'b1101
    } aluOp_e;

    typedef enum logic [1:0] {
        SH_LSL = 2'b00,
        SH_LSR = 2'b01,
        SH_ASR = 2'b10,
        SH_ROR = 2'b11
    } shiftType_e;

    typedef struct packed {
        condCode_e   cond;
        logic [1:0]  fmt;       // 2'b00
        logic        immSel;    // I bit
        aluOp_e      opcode;
        logic        setFlags;  // S bit
        regIdx_t     rn;
        regIdx_t     rd;
        logic [11:0] operand2;  // rot/imm8 or shamt/type/rm
    } dpFields_t;

    typedef struct packed {
        condCode_e   cond;
        logic [1:0]  fmt;        // 2'b01
        logic        regOffset;  // Set means register offset, unsupported
        logic        preIndex;
        logic        up;         // Add offset when set
        logic        byteAcc;
        logic        writeBack;
        logic        load;
        regIdx_t     rn;
        regIdx_t     rd;
        logic [11:0] offset;
    } memFields_t;

    typedef struct packed {
        condCode_e   cond;
        logic [1:0]  fmt;    // 2'b10
        logic        fixed;  // Always 1 for B/BL
        logic        link;
        logic [23:0] offset;
    } brFields_t;

    typedef union packed {
        dpFields_t  dp;
        memFields_t mem;
        brFields_t  br;
    } instr_u;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        condCode_e   cond;
        aluOp_e      aluOp;
        logic        setFlags;
        logic        immSel;
        logic        regWrite;
        regIdx_t     rd;
        regIdx_t     rn;
        regIdx_t     rm;
        logic        memRead;
        logic        memWrite;
        logic        addOffset;
        logic        branch;
        shiftType_e  shType;
        logic [4:0]  shAmt;
        logic [23:0] imm;  // imm8, 12-bit offset or 24-bit branch offset
    } ctrl_t;

    typedef struct packed {
        logic  write;
        word_t addr;
        word_t wdata;
    } memBus_t;

endpackage

`default_nettype wire

// File: verilog/InstructionMemory.sv
`timescale 1ns/1ps
`default_nettype none

module InstructionMemory
    import armPkg::*;
(
    input  word_t pc,
    output word_t instr
);

    word_t       rom [IMEM_WORDS];
    logic [29:0] wordAddr;

    initial begin
        for (int i = 0; i < IMEM_WORDS; i++) begin
            rom[i] = '0;  // Words past the program stay zero
        end
        $readmemh(PROGRAM_FILE, rom);
    end

    assign wordAddr = pc[31:2];

    // Fetches outside the ROM read as zero
    assign instr = (wordAddr < IMEM_WORDS) ? rom[wordAddr[IMEM_ADDR_W-1:0]] : '0;

endmodule

`default_nettype wire

// File: verilog/dataMemory.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemory
    import armPkg::*;
(
    input  logic    clk,
    input  memBus_t dataBus,
    output word_t   readData
);

    word_t                  ram [DMEM_WORDS];
    logic [DMEM_ADDR_W-1:0] wordAddr;

    initial begin
        for (int i = 0; i < DMEM_WORDS; i++) begin
            ram[i] = '0;
        end
    end

    assign wordAddr = dataBus.addr[DMEM_ADDR_W+1:2];  // Word index, upper bits wrap

    // Store commits at the edge that ends the instruction
    always_ff @(posedge clk) begin
        if (dataBus.write) begin
            ram[wordAddr] <= dataBus.wdata;
        end
    end

    // Load data is ready in the same cycle
    assign readData = ram[wordAddr];

endmodule

`default_nettype wire

// File: core/controlDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module controlDecoder
    import armPkg::*;
(
    input  instr_u instr,
    output ctrl_t  ctrl
);

    logic condOk;
    logic dpOk;
    logic memOk;
    logic brOk;

    // Only EQ, NE and AL are executed, other conditions turn into no-ops
    assign condOk = (instr.dp.cond == COND_EQ) || (instr.dp.cond == COND_NE) ||
                    (instr.dp.cond == COND_AL);

    always_comb begin
        dpOk = instr.dp.opcode inside {OP_AND, OP_SUB, OP_ADD, OP_ORR, OP_CMP, OP_MOV};
        dpOk = dpOk && (instr.dp.immSel || !instr.dp.operand2[4]);  // No register shift amount
        memOk = !instr.mem.regOffset && instr.mem.preIndex && !instr.mem.byteAcc &&
                !instr.mem.writeBack;
        brOk = instr.br.fixed && !instr.br.link;  // Plain B only

        ctrl = '0;
        case (instr.dp.fmt)
            2'b00: begin
                if (condOk && dpOk) begin
                    ctrl.cond     = instr.dp.cond;
                    ctrl.aluOp    = instr.dp.opcode;
                    ctrl.immSel   = instr.dp.immSel;
                    ctrl.rn       = instr.dp.rn;
                    ctrl.rd       = instr.dp.rd;
                    ctrl.rm       = instr.dp.operand2[3:0];
                    ctrl.setFlags = instr.dp.setFlags || (instr.dp.opcode == OP_CMP);
                    ctrl.regWrite = (instr.dp.opcode != OP_CMP);
                    if (instr.dp.immSel) begin
                        // Rotated immediate goes through the shifter as ROR by 2*rot
                        ctrl.shType = SH_ROR;
                        ctrl.shAmt  = {instr.dp.operand2[11:8], 1'b0};
                        ctrl.imm    = {16'b0, instr.dp.operand2[7:0]};
                    end else begin
                        ctrl.shType = shiftType_e'(instr.dp.operand2[6:5]);
                        ctrl.shAmt  = instr.dp.operand2[11:7];
                    end
                end
            end
            2'b01: begin
                if (condOk && memOk) begin
                    ctrl.cond      = instr.mem.cond;
                    ctrl.aluOp     = OP_ADD;
                    ctrl.immSel    = 1'b1;
                    ctrl.rn        = instr.mem.rn;
                    ctrl.rd        = instr.mem.rd;  // Load target or store source
                    ctrl.regWrite  = instr.mem.load;
                    ctrl.memRead   = instr.mem.load;
                    ctrl.memWrite  = !instr.mem.load;
                    ctrl.addOffset = instr.mem.up;
                    ctrl.imm       = {12'b0, instr.mem.offset};
                end
            end
            2'b10: begin
                if (condOk && brOk) begin
                    ctrl.cond   = instr.br.cond;
                    ctrl.branch = 1'b1;
                    ctrl.imm    = instr.br.offset;
                end
            end
            default: begin
                ctrl = '0;  // Coprocessor space
            end
        endcase
    end

endmodule

`default_nettype wire

// File: core/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile
    import armPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  ctrl_t ctrl,
    input  logic  condPass,
    input  word_t aluResult,
    input  word_t readData,
    input  word_t branchTarget,
    output word_t pc,
    output word_t rn,
    output word_t rm,
    output word_t rd
);

    word_t regs [GPR_COUNT];
    word_t pcReg;
    word_t pcRead;     // Value seen when R15 is a source
    word_t writeData;

    assign pc     = pcReg;
    assign pcRead = pcReg + PC_READ_OFFSET;

    always_comb begin
        rn = (ctrl.rn == PC_REG) ? pcRead : regs[ctrl.rn];
        rm = (ctrl.rm == PC_REG) ? pcRead : regs[ctrl.rm];
        rd = (ctrl.rd == PC_REG) ? pcRead : regs[ctrl.rd];  // Store data
    end

    assign writeData = ctrl.memRead ? readData : aluResult;

    always_ff @(posedge clk) begin
        if (rst) begin
            pcReg <= '0;
            for (int i = 0; i < GPR_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (ctrl.branch && condPass) begin
                pcReg <= branchTarget;
            end else begin
                pcReg <= pcReg + 32'd4;
            end
            // Writes to R15 are not part of the subset
            if (ctrl.regWrite && condPass && (ctrl.rd != PC_REG)) begin
                regs[ctrl.rd] <= writeData;
            end
        end
    end

endmodule

`default_nettype wire

// File: core/executeUnit.sv
`timescale 1ns/1ps
`default_nettype none

module executeUnit
    import armPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  ctrl_t   ctrl,
    input  word_t   rn,
    input  word_t   rm,
    input  word_t   rd,
    input  word_t   pc,
    output word_t   aluResult,
    output word_t   branchTarget,
    output logic    condPass,
    output memBus_t dataBus
);

    flags_t             flags;     // Stored NZCV
    flags_t             aluFlags;
    word_t              shSrc;
    word_t              operand2;
    logic               shCarry;
    logic signed [32:0] asrTmp;
    logic [63:0]        rorTmp;
    logic [32:0]        sum;
    word_t              memAddr;

    // Barrel shifter
    always_comb begin
        shSrc  = ctrl.immSel ? {24'b0, ctrl.imm[7:0]} : rm;
        asrTmp = $signed({shSrc, 1'b0}) >>> ctrl.shAmt;
        rorTmp = {shSrc, shSrc} >> ctrl.shAmt;
        case (ctrl.shType)
            SH_LSL: {shCarry, operand2} = {flags.c, shSrc} << ctrl.shAmt;  // Amount 0 keeps C
            SH_LSR: begin
                if (ctrl.shAmt == 5'd0) begin
                    operand2 = '0;  // Encodes LSR #32
                    shCarry  = shSrc[31];
                end else begin
                    {operand2, shCarry} = {shSrc, 1'b0} >> ctrl.shAmt;
                end
            end
            SH_ASR: begin
                if (ctrl.shAmt == 5'd0) begin
                    operand2 = {32{shSrc[31]}};
                    shCarry  = shSrc[31];
                end else begin
                    {operand2, shCarry} = asrTmp;
                end
            end
            default: begin
                if (ctrl.shAmt == 5'd0 && !ctrl.immSel) begin
                    operand2 = {flags.c, shSrc[31:1]};  // RRX
                    shCarry  = shSrc[0];
                end else begin
                    operand2 = rorTmp[31:0];
                    shCarry  = (ctrl.shAmt == 5'd0) ? flags.c : rorTmp[31];
                end
            end
        endcase
    end

    // ALU and next flags
    always_comb begin
        sum       = '0;
        aluFlags  = flags;
        aluResult = '0;
        case (ctrl.aluOp)
            OP_AND: begin
                aluResult  = rn & operand2;
                aluFlags.c = shCarry;
            end
            OP_ORR: begin
                aluResult  = rn | operand2;
                aluFlags.c = shCarry;
            end
            OP_MOV: begin
                aluResult  = operand2;
                aluFlags.c = shCarry;
            end
            OP_ADD: begin
                sum        = {1'b0, rn} + {1'b0, operand2};
                aluResult  = sum[31:0];
                aluFlags.c = sum[32];
                aluFlags.v = (rn[31] == operand2[31]) && (aluResult[31] != rn[31]);
            end
            OP_SUB, OP_CMP: begin
                sum        = {1'b0, rn} + {1'b0, ~operand2} + 33'd1;
                aluResult  = sum[31:0];
                aluFlags.c = sum[32];  // Carry set means no borrow
                aluFlags.v = (rn[31] != operand2[31]) && (aluResult[31] != rn[31]);
            end
            default: aluResult = '0;
        endcase
        aluFlags.n = aluResult[31];
        aluFlags.z = (aluResult == '0);
    end

    always_comb begin
        case (ctrl.cond)
            COND_EQ: condPass = flags.z;
            COND_NE: condPass = !flags.z;
            COND_AL: condPass = 1'b1;
            default: condPass = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (ctrl.setFlags && condPass) begin
            flags <= aluFlags;
        end
    end

    // Pre-indexed address without writeback
    assign memAddr = ctrl.addOffset ? rn + {20'b0, ctrl.imm[11:0]} : rn - {20'b0, ctrl.imm[11:0]};

    assign branchTarget = pc + PC_READ_OFFSET + {{6{ctrl.imm[23]}}, ctrl.imm, 2'b00};

    always_comb begin
        dataBus.write = ctrl.memWrite && condPass && !rst;  // Strobe stays low in reset
        dataBus.addr  = memAddr;
        dataBus.wdata = rd;
    end

endmodule

`default_nettype wire

// File: verilog/processorTop.sv
`timescale 1ns/1ps
`default_nettype none

module processorTop
    import armPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    output word_t   pc,
    output memBus_t dataBus
);

    word_t instrWord;
    ctrl_t ctrl;
    word_t rnVal;
    word_t rmVal;
    word_t rdVal;        // Store data
    word_t aluResult;
    word_t branchTarget;
    word_t readData;
    logic  condPass;

    InstructionMemory instrMem_i (
        .pc    (pc),
        .instr (instrWord)
    );

    // Raw fetch word feeds the union port directly
    controlDecoder decoder_i (
        .instr (instrWord),
        .ctrl  (ctrl)
    );

    registerFile regFile_i (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl),
        .condPass     (condPass),
        .aluResult    (aluResult),
        .readData     (readData),
        .branchTarget (branchTarget),
        .pc           (pc),
        .rn           (rnVal),
        .rm           (rmVal),
        .rd           (rdVal)
    );

    executeUnit exec_i (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl),
        .rn           (rnVal),
        .rm           (rmVal),
        .rd           (rdVal),
        .pc           (pc),
        .aluResult    (aluResult),
        .branchTarget (branchTarget),
        .condPass     (condPass),
        .dataBus      (dataBus)
    );

    dataMemory dataMem_i (
        .clk      (clk),
        .dataBus  (dataBus),
        .readData (readData)
    );

endmodule

`default_nettype wire

// File: test/tbProcessor.sv
`timescale 1ns/1ps
`default_nettype none

module tbProcessor
    import armPkg::*;
();

    localparam int    CLK_PERIOD     = 20;
    localparam int    RESET_CYCLES   = 5;
    localparam int    DRIVE_DELAY    = 1;
    localparam int    TIMEOUT_CYCLES = 200;  // Program needs about 70 cycles
    localparam int    HALT_CYCLES    = 10;
    localparam word_t HALT_ADDR      = 32'h0000_00A8;  // Word 42 of the program

    // Constants loaded by the program's first two MOVs
    localparam word_t R1 = 32'h0000_002C;
    localparam word_t R2 = 32'h0000_0011;

    logic    clk;
    logic    rst;
    word_t   pc;
    memBus_t dataBus;

    processorTop processorTop_i (
        .clk     (clk),
        .rst     (rst),
        .pc      (pc),
        .dataBus (dataBus)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic checkWord(input word_t actual, input word_t expected, input string name);
        string line;
        if (actual !== expected) begin
            line = $sformatf("MISMATCH %s: expected 0x%08h, got 0x%08h", name, expected, actual);
            abortRun(line);
        end
    endtask

    // The strobe itself is what selects the sampled cycle
    task automatic checkBus(input memBus_t actual, input memBus_t expected);
        checkWord(actual.addr, expected.addr, "dataBus.addr");
        checkWord(actual.wdata, expected.wdata, "dataBus.wdata");
    endtask

    // Mid-cycle sample, so the bus is settled
    task automatic captureStore(output memBus_t bus);
        do begin
            @(negedge clk);
        end while (dataBus.write !== 1'b1);
        bus = dataBus;
    endtask

    task automatic expectStore(input word_t addr, input word_t data);
        memBus_t seen;
        memBus_t expected;
        captureStore(seen);
        expected.addr  = addr;
        expected.wdata = data;
        checkBus(seen, expected);
    endtask

    task automatic checkAluOps();
        @(negedge clk);
        checkWord(pc, 32'h0, "pc");  // First instruction after reset
        expectStore(32'h00, R1 + R2);
        expectStore(32'h04, R1 - R2);
        expectStore(32'h08, R1 & R2);
        expectStore(32'h0C, R1 | R2);
    endtask

    task automatic checkShifts();
        word_t diff;
        diff = R2 - R1;
        expectStore(32'h10, R1 << 4);
        expectStore(32'h14, diff);
        expectStore(32'h18, word_t'($signed(diff) >>> 2));  // Sign bit fills from the top
        expectStore(32'h1C, diff >> 2);
        expectStore(32'h20, (R1 >> 4) | (R1 << 28));
    endtask

    task automatic checkLoadStore();
        word_t loaded;
        loaded = R1 - R2;  // Word stored at address 4 earlier
        expectStore(32'h40, loaded + 32'd1);
        expectStore(32'h48 - 32'd4, loaded + 32'd1);  // Subtracted offset from r12
    endtask

    task automatic checkBranchLoop();
        word_t total;
        total = '0;
        for (int pass = 0; pass < 3; pass++) begin
            total = total + 32'd5;
        end
        expectStore(32'h48, total);
    endtask

    task automatic checkConditions();
        // R1 differs from R2 so BEQ falls through
        expectStore(32'h4C, 32'h0000_00A5);
        // Equal compare skips the 0xFF store
        expectStore(32'h50, 32'h0000_005A);
    endtask

    task automatic checkHalt();
        while (pc !== HALT_ADDR) begin
            @(negedge clk);
        end
        repeat (HALT_CYCLES) begin
            @(negedge clk);
            checkWord(pc, HALT_ADDR, "pc");
            if (dataBus.write !== 1'b0) begin
                abortRun("A store was issued while the program was halted");
            end
        end
    endtask

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        abortRun("Watchdog expired before the program reached its halt loop");
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY) rst = 1'b0;

        checkAluOps();
        checkShifts();
        checkLoadStore();
        checkBranchLoop();
        checkConditions();
        checkHalt();

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: processor.f
common/armPkg.sv
verilog/InstructionMemory.sv
verilog/dataMemory.sv
core/controlDecoder.sv
core/registerFile.sv
core/executeUnit.sv
verilog/processorTop.sv
test/tbProcessor.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    -f processor.f \
    --top-module tbProcessor \
    -o simProcessor
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOutput=$(./obj_dir/simProcessor 2>&1)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOutput" | grep -q "Test passed"; then
    exit 0
else
    exit 1
fi

// File: test/program.hex
// One 32-bit ARM instruction per line in hex, from word address 0 upward
// Column 1 is the instruction word, the comment gives its assembly
E3A0102C  // MOV  r1, #0x2C
E3A02011  // MOV  r2, #0x11
E3A00000  // MOV  r0, #0
E0813002  // ADD  r3, r1, r2
E5803000  // STR  r3, [r0, #0]
E0413002  // SUB  r3, r1, r2
E5803004  // STR  r3, [r0, #4]
E0013002  // AND  r3, r1, r2
E5803008  // STR  r3, [r0, #8]
E1813002  // ORR  r3, r1, r2
E580300C  // STR  r3, [r0, #12]
E1A03201  // MOV  r3, r1, LSL #4
E5803010  // STR  r3, [r0, #16]
E0424001  // SUB  r4, r2, r1
E5804014  // STR  r4, [r0, #20]
E1A03144  // MOV  r3, r4, ASR #2
E5803018  // STR  r3, [r0, #24]
E1A03124  // MOV  r3, r4, LSR #2
E580301C  // STR  r3, [r0, #28]
E1A03261  // MOV  r3, r1, ROR #4
E5803020  // STR  r3, [r0, #32]
E5905004  // LDR  r5, [r0, #4]
E2855001  // ADD  r5, r5, #1
E5805040  // STR  r5, [r0, #0x40]
E3A0C048  // MOV  r12, #0x48
E50C5004  // STR  r5, [r12, #-4]
E3A06003  // MOV  r6, #3
E3A07000  // MOV  r7, #0
E2877005  // loop: ADD r7, r7, #5
E2566001  // SUBS r6, r6, #1
1AFFFFFC  // BNE  loop
E5807048  // STR  r7, [r0, #0x48]
E1510002  // CMP  r1, r2
0A000001  // BEQ  +1, not taken
E3A080A5  // MOV  r8, #0xA5
E580804C  // STR  r8, [r0, #0x4C]
E1510001  // CMP  r1, r1
0A000001  // BEQ  +1, taken
E3A090FF  // MOV  r9, #0xFF
E5809050  // STR  r9, [r0, #0x50]
E3A0905A  // MOV  r9, #0x5A
E5809050  // STR  r9, [r0, #0x50]
EAFFFFFE  // halt: B halt
